/* pipeline_cases.txt */
# Header: test number, word count, final PC (hex), number of register checks
# Then one instruction word (hex) per line, then lines of register (decimal) and value (hex)
1 10 24 9
20010005
20220003
00221820
00612022
00832824
00a13025
0026382a
00264022
0101482a
1000ffff
1 5
2 8
3 d
4 8
5 8
6 d
7 1
8 fffffff8
9 1
2 9 20 7
20010077
ac010008
8c020008
00411820
20000009
00012020
8c050008
00253020
1000ffff
0 0
1 77
2 77
3 ee
4 77
5 77
6 ee
3 9 20 9
20010004
20020004
10220004
20030001
20040001
20050001
20060001
00223820
1000ffff
1 4
2 4
3 0
4 0
5 0
6 0
7 8
8 0
9 0
4 7 18 6
20010003
20020005
10220002
20030007
20640001
00222825
1000ffff
1 3
2 5
3 7
4 8
5 7
7 0

/* list.f */
mips_pkg.sv
stall_unit.sv
forwarding_unit.sv
register_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
mips_pipeline.sv
tb_mips_pipeline_assert.sv
tb_mips_pipeline.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_mips_pipeline -f list.f
./obj_dir/Vtb_mips_pipeline

/* tb_mips_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mips_pipeline import mips_pkg::*; ();

    localparam int RESET_CYCLES   = 10;
    localparam int DRAIN_CYCLES   = 8;  // Last write-back plus margin
    localparam int TIMEOUT_MARGIN = 40;
    localparam int MAX_WORDS      = 10; // Whole program goes in during reset
    localparam int MAX_CHECKS     = 32;

    logic       clock;
    logic       reset;
    logic       imem_we;
    logic [5:0] imem_addr;
    t_word      imem_data;
    t_reg_idx   dbg_reg;
    t_word      dbg_data;
    t_word      pc;

    int       fd;
    int       seed = 32'h4ad3_2733; // Only shuffles the debug read order
    int       test_num;
    int       nwords;
    int       nchecks;
    t_word    final_pc;             // Address of the closing self loop
    t_word    words [MAX_WORDS];
    t_reg_idx exp_reg [MAX_CHECKS];
    t_word    exp_val [MAX_CHECKS];
    int       order [MAX_CHECKS];

    mips_pipeline #(.IMEM_DEPTH(64), .DMEM_DEPTH(64)) mips_pipeline_i (
        .i_clock     (clock),
        .i_reset     (reset),
        .i_imem_we   (imem_we),
        .i_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .i_dbg_reg   (dbg_reg),
        .o_dbg_data  (dbg_data),
        .o_pc        (pc)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock; // 8 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input t_word expected, input t_word actual);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch %s: expected 0x%08h, actual 0x%08h",
                                name, expected, actual));
        end
    endtask

    // Next line that holds data, comment lines skipped
    task automatic next_line(output string line, output bit found);
        int code;
        found = 1'b0;
        line  = "";
        while (!found && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                found = 1'b1;
            end
        end
    endtask

    task automatic read_block(output bit found);
        string line;
        int    code;
        next_line(line, found);
        if (found) begin
            code = $sscanf(line, "%d %d %h %d", test_num, nwords, final_pc, nchecks);
            if (code != 4 || nwords < 1 || nwords > MAX_WORDS || nchecks > MAX_CHECKS) begin
                abort_run($sformatf("Bad block header in the cases file: %s", line));
            end
            for (int i = 0; i < nwords; i++) begin
                next_line(line, found);
                code = $sscanf(line, "%h", words[i]);
                if (!found || code != 1) begin
                    abort_run("The cases file ends in the middle of a program");
                end
            end
            for (int i = 0; i < nchecks; i++) begin
                next_line(line, found);
                code = $sscanf(line, "%d %h", exp_reg[i], exp_val[i]);
                if (!found || code != 2) begin
                    abort_run("The cases file ends in the middle of the expected values");
                end
            end
        end
    endtask

    // Imem writes only count while reset is high
    task automatic load_program();
        for (int k = 0; k < RESET_CYCLES; k++) begin
            @(posedge clock);
            reset     <= 1'b1;
            imem_we   <= (k < nwords);
            imem_addr <= k[5:0];
            imem_data <= (k < nwords) ? words[k] : '0;
        end
        @(negedge clock);
        check_value("o_pc", 32'h0000_0000, pc); // Reset holds fetch at address 0
        @(posedge clock);
        reset   <= 1'b0; // Last word lands on this edge
        imem_we <= 1'b0;
    endtask

    task automatic wait_for_final_pc();
        int cycles;
        int limit;
        cycles = 0;
        limit  = 4 * nwords + TIMEOUT_MARGIN;
        @(negedge clock);
        while (pc !== final_pc) begin
            cycles++;
            if (cycles > limit) begin
                abort_run($sformatf("Timeout: test %0d did not reach PC 0x%08h in %0d cycles",
                                    test_num, final_pc, limit));
            end
            @(negedge clock);
        end
    endtask

    task automatic check_registers();
        int j;
        int tmp;
        for (int i = 0; i < nchecks; i++) begin
            order[i] = i;
        end
        for (int i = nchecks - 1; i > 0; i--) begin
            j        = {$random(seed)} % (i + 1); // Fisher-Yates shuffle
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < nchecks; i++) begin
            @(posedge clock);
            dbg_reg <= exp_reg[order[i]];
            @(negedge clock); // Debug port is combinational
            check_value($sformatf("o_dbg_data (register %0d)", exp_reg[order[i]]),
                        exp_val[order[i]], dbg_data);
        end
    endtask

    initial begin
        bit found;
        reset     = 1'b1;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        dbg_reg   = '0;
        fd = $fopen("pipeline_cases.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open pipeline_cases.txt");
        end
        read_block(found);
        if (!found) begin
            abort_run("No test block found in pipeline_cases.txt");
        end
        while (found) begin
            load_program();
            wait_for_final_pc();
            repeat (DRAIN_CYCLES) @(posedge clock); // Let the tail retire
            check_registers();
            $display("Block %0d done, %0d registers checked", test_num, nchecks);
            read_block(found);
        end
        $fclose(fd);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_mips_pipeline_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mips_pipeline_assert (
    input wire i_clock,
    input wire i_reset,
    input wire i_enable_pc,          // Stall unit outputs
    input wire i_enable_if_id,
    input wire i_select_control_nop,
    input wire i_flush_if,
    input wire i_flush_ex
);

    enables_match: assert property (@(posedge i_clock) i_enable_pc == i_enable_if_id)
        else $error("PC and IF/ID enables differ");

    flush_is_complete: assert property (@(posedge i_clock)
        i_flush_if |-> (i_flush_ex && i_select_control_nop))
        else $error("IF flush without EX flush and ID/EX no-op");

    stall_is_bubble: assert property (@(posedge i_clock)
        !i_enable_pc |-> (i_select_control_nop && !i_flush_if && !i_flush_ex))
        else $error("Stall without a bubble, or stall together with a flush");

    reset_is_quiet: assert property (@(posedge i_clock)
        i_reset |-> (i_enable_pc && i_enable_if_id && !i_select_control_nop &&
                     !i_flush_if && !i_flush_ex))
        else $error("Stall unit active during reset");

endmodule

// Stall unit has no clock, so its outputs are watched in the core
bind mips_pipeline tb_mips_pipeline_assert stall_checks_i (
    .i_clock              (i_clock),
    .i_reset              (i_reset),
    .i_enable_pc          (enable_pc),
    .i_enable_if_id       (enable_if_id),
    .i_select_control_nop (select_control_nop),
    .i_flush_if           (flush_if),
    .i_flush_ex           (flush_ex)
);

`default_nettype wire

/* mips_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_pipeline import mips_pkg::*; #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  wire                          i_clock,
    input  wire                          i_reset,
    input  wire                          i_imem_we,   // Program load during reset
    input  wire [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
    input  wire t_word                   i_imem_data,
    input  wire t_reg_idx                i_dbg_reg,
    output t_word                        o_dbg_data,
    output t_word                        o_pc
);

    t_word    if_id_instr, if_id_pc_plus4;
    t_reg_idx if_id_rs, if_id_rt;
    t_word    id_ex_rs_data, id_ex_rt_data, id_ex_imm, id_ex_pc_plus4;
    t_reg_idx id_ex_rs, id_ex_rt, id_ex_rd;
    t_alu_ctl id_ex_alu_ctl;
    logic     id_ex_alu_src, id_ex_reg_write, id_ex_mem_read, id_ex_mem_write, id_ex_branch;
    t_word    ex_mem_result, ex_mem_store_data, ex_mem_branch_target;
    t_reg_idx ex_mem_rd;
    logic     ex_mem_zero, ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write, ex_mem_branch;
    logic     wb_we, branch_taken;
    t_reg_idx wb_reg;
    t_word    wb_data, branch_target;
    logic     enable_pc, enable_if_id, flush_if, select_control_nop, flush_ex;
    t_fwd_sel fwd_a, fwd_b;

    fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) fetch_stage_i (
        .i_clock(i_clock), .i_reset(i_reset),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
        .i_enable_pc(enable_pc), .i_enable_if_id(enable_if_id), .i_flush_if(flush_if),
        .i_branch_taken(branch_taken), .i_branch_target(branch_target),
        .o_pc(o_pc), .o_if_id_instr(if_id_instr), .o_if_id_pc_plus4(if_id_pc_plus4)
    );

    decode_stage decode_stage_i (
        .i_clock(i_clock), .i_reset(i_reset),
        .i_if_id_instr(if_id_instr), .i_if_id_pc_plus4(if_id_pc_plus4),
        .i_select_control_nop(select_control_nop),
        .i_wb_we(wb_we), .i_wb_reg(wb_reg), .i_wb_data(wb_data),
        .i_dbg_reg(i_dbg_reg), .o_dbg_data(o_dbg_data),
        .o_if_id_rs(if_id_rs), .o_if_id_rt(if_id_rt),
        .o_id_ex_rs_data(id_ex_rs_data), .o_id_ex_rt_data(id_ex_rt_data),
        .o_id_ex_rs(id_ex_rs), .o_id_ex_rt(id_ex_rt), .o_id_ex_rd(id_ex_rd),
        .o_id_ex_imm(id_ex_imm), .o_id_ex_pc_plus4(id_ex_pc_plus4),
        .o_id_ex_alu_ctl(id_ex_alu_ctl), .o_id_ex_alu_src(id_ex_alu_src),
        .o_id_ex_reg_write(id_ex_reg_write), .o_id_ex_mem_read(id_ex_mem_read),
        .o_id_ex_mem_write(id_ex_mem_write), .o_id_ex_branch(id_ex_branch)
    );

    execute_stage execute_stage_i (
        .i_clock(i_clock), .i_reset(i_reset),
        .i_id_ex_rs_data(id_ex_rs_data), .i_id_ex_rt_data(id_ex_rt_data),
        .i_id_ex_rd(id_ex_rd), .i_id_ex_imm(id_ex_imm), .i_id_ex_pc_plus4(id_ex_pc_plus4),
        .i_id_ex_alu_ctl(id_ex_alu_ctl), .i_id_ex_alu_src(id_ex_alu_src),
        .i_id_ex_reg_write(id_ex_reg_write), .i_id_ex_mem_read(id_ex_mem_read),
        .i_id_ex_mem_write(id_ex_mem_write), .i_id_ex_branch(id_ex_branch),
        .i_fwd_a(fwd_a), .i_fwd_b(fwd_b),
        .i_ex_mem_result(ex_mem_result), .i_wb_data(wb_data), .i_flush_ex(flush_ex),
        .o_ex_mem_result(ex_mem_result), .o_ex_mem_store_data(ex_mem_store_data),
        .o_ex_mem_branch_target(ex_mem_branch_target), .o_ex_mem_zero(ex_mem_zero),
        .o_ex_mem_rd(ex_mem_rd), .o_ex_mem_reg_write(ex_mem_reg_write),
        .o_ex_mem_mem_read(ex_mem_mem_read), .o_ex_mem_mem_write(ex_mem_mem_write),
        .o_ex_mem_branch(ex_mem_branch)
    );

    memory_stage #(.DMEM_DEPTH(DMEM_DEPTH)) memory_stage_i (
        .i_clock(i_clock), .i_reset(i_reset),
        .i_ex_mem_result(ex_mem_result), .i_ex_mem_store_data(ex_mem_store_data),
        .i_ex_mem_branch_target(ex_mem_branch_target), .i_ex_mem_zero(ex_mem_zero),
        .i_ex_mem_rd(ex_mem_rd), .i_ex_mem_reg_write(ex_mem_reg_write),
        .i_ex_mem_mem_read(ex_mem_mem_read), .i_ex_mem_mem_write(ex_mem_mem_write),
        .i_ex_mem_branch(ex_mem_branch),
        .o_branch_taken(branch_taken), .o_branch_target(branch_target),
        .o_wb_we(wb_we), .o_wb_reg(wb_reg), .o_wb_data(wb_data)
    );

    stall_unit stall_unit_i (
        .i_reset(i_reset), .i_branch_taken(branch_taken),
        .i_id_ex_mem_read(id_ex_mem_read), .i_id_ex_rt(id_ex_rt),
        .i_if_id_rt(if_id_rt), .i_if_id_rs(if_id_rs),
        .o_select_control_nop(select_control_nop), .o_enable_if_id(enable_if_id),
        .o_enable_pc(enable_pc), .o_flush_if(flush_if), .o_flush_ex(flush_ex)
    );

    forwarding_unit forwarding_unit_i (
        .i_id_ex_rs(id_ex_rs), .i_id_ex_rt(id_ex_rt),
        .i_ex_mem_rd(ex_mem_rd), .i_ex_mem_reg_write(ex_mem_reg_write),
        .i_mem_wb_rd(wb_reg), .i_mem_wb_reg_write(wb_we), // MEM/WB is the write-back
        .o_fwd_a(fwd_a), .o_fwd_b(fwd_b)
    );

endmodule

`default_nettype wire

/* memory_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module memory_stage import mips_pkg::*; #(
    parameter int DMEM_DEPTH = 64
) (
    input  wire           i_clock,
    input  wire           i_reset,
    input  wire t_word    i_ex_mem_result,        // Address or ALU value
    input  wire t_word    i_ex_mem_store_data,
    input  wire t_word    i_ex_mem_branch_target,
    input  wire           i_ex_mem_zero,
    input  wire t_reg_idx i_ex_mem_rd,
    input  wire           i_ex_mem_reg_write,
    input  wire           i_ex_mem_mem_read,
    input  wire           i_ex_mem_mem_write,
    input  wire           i_ex_mem_branch,
    output logic          o_branch_taken,
    output t_word         o_branch_target,
    output logic          o_wb_we,
    output t_reg_idx      o_wb_reg,
    output t_word         o_wb_data
);

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    t_word dmem [DMEM_DEPTH];
    t_word load_data;
    logic  mem_wb_mem_read; // Write back the load data
    t_word mem_wb_load;
    t_word mem_wb_alu;

    assign load_data       = dmem[i_ex_mem_result[DMEM_AW+1:2]]; // Word access
    assign o_branch_taken  = i_ex_mem_branch && i_ex_mem_zero;   // beq operands equal
    assign o_branch_target = i_ex_mem_branch_target;
    assign o_wb_data       = mem_wb_mem_read ? mem_wb_load : mem_wb_alu;

    always_ff @(posedge i_clock) begin
        if (i_ex_mem_mem_write) dmem[i_ex_mem_result[DMEM_AW+1:2]] <= i_ex_mem_store_data;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_wb_we         <= 1'b0;
            mem_wb_mem_read <= 1'b0;
        end else begin
            o_wb_we         <= i_ex_mem_reg_write;
            mem_wb_mem_read <= i_ex_mem_mem_read;
        end
    end

    always_ff @(posedge i_clock) begin
        o_wb_reg    <= i_ex_mem_rd;
        mem_wb_load <= load_data;
        mem_wb_alu  <= i_ex_mem_result;
    end

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_stage import mips_pkg::*; (
    input  wire           i_clock,
    input  wire           i_reset,
    input  wire t_word    i_id_ex_rs_data,
    input  wire t_word    i_id_ex_rt_data,
    input  wire t_reg_idx i_id_ex_rd,
    input  wire t_word    i_id_ex_imm,
    input  wire t_word    i_id_ex_pc_plus4,
    input  wire t_alu_ctl i_id_ex_alu_ctl,
    input  wire           i_id_ex_alu_src,
    input  wire           i_id_ex_reg_write,
    input  wire           i_id_ex_mem_read,
    input  wire           i_id_ex_mem_write,
    input  wire           i_id_ex_branch,
    input  wire t_fwd_sel i_fwd_a,
    input  wire t_fwd_sel i_fwd_b,
    input  wire t_word    i_ex_mem_result, // Forward path one stage ahead
    input  wire t_word    i_wb_data,       // Forward path two stages ahead
    input  wire           i_flush_ex,
    output t_word         o_ex_mem_result,
    output t_word         o_ex_mem_store_data,
    output t_word         o_ex_mem_branch_target,
    output logic          o_ex_mem_zero,
    output t_reg_idx      o_ex_mem_rd,
    output logic          o_ex_mem_reg_write,
    output logic          o_ex_mem_mem_read,
    output logic          o_ex_mem_mem_write,
    output logic          o_ex_mem_branch
);

    t_word op_a, op_rt, op_b, alu_result;

    function automatic t_word fwd_mux(input t_fwd_sel sel, input t_word reg_val,
                                      input t_word exmem, input t_word memwb);
        case (sel)
            FWD_EXMEM: return exmem;
            FWD_MEMWB: return memwb;
            default:   return reg_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(i_fwd_a, i_id_ex_rs_data, i_ex_mem_result, i_wb_data);
    assign op_rt = fwd_mux(i_fwd_b, i_id_ex_rt_data, i_ex_mem_result, i_wb_data);
    assign op_b  = i_id_ex_alu_src ? i_id_ex_imm : op_rt; // addi lw sw

    always_comb begin
        case (i_id_ex_alu_ctl)
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_SLT: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            default: alu_result = op_a + op_b;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset || i_flush_ex) begin
            o_ex_mem_reg_write <= 1'b0;
            o_ex_mem_mem_read  <= 1'b0;
            o_ex_mem_mem_write <= 1'b0; // No store from a killed instruction
            o_ex_mem_branch    <= 1'b0;
        end else begin
            o_ex_mem_reg_write <= i_id_ex_reg_write;
            o_ex_mem_mem_read  <= i_id_ex_mem_read;
            o_ex_mem_mem_write <= i_id_ex_mem_write;
            o_ex_mem_branch    <= i_id_ex_branch;
        end
    end

    always_ff @(posedge i_clock) begin
        o_ex_mem_result        <= alu_result;
        o_ex_mem_store_data    <= op_rt; // Forwarded rt for sw
        o_ex_mem_branch_target <= i_id_ex_pc_plus4 + {i_id_ex_imm[29:0], 2'b00};
        o_ex_mem_zero          <= (alu_result == '0);
        o_ex_mem_rd            <= i_id_ex_rd;
    end

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage import mips_pkg::*; (
    input  wire           i_clock,
    input  wire           i_reset,
    input  wire t_word    i_if_id_instr,
    input  wire t_word    i_if_id_pc_plus4,
    input  wire           i_select_control_nop, // Bubble or flush into EX
    input  wire           i_wb_we,              // Write-back from MEM/WB
    input  wire t_reg_idx i_wb_reg,
    input  wire t_word    i_wb_data,
    input  wire t_reg_idx i_dbg_reg,
    output t_word         o_dbg_data,
    output t_reg_idx      o_if_id_rs,           // To the stall unit
    output t_reg_idx      o_if_id_rt,
    output t_word         o_id_ex_rs_data,
    output t_word         o_id_ex_rt_data,
    output t_reg_idx      o_id_ex_rs,
    output t_reg_idx      o_id_ex_rt,
    output t_reg_idx      o_id_ex_rd,           // Destination, rt or rd
    output t_word         o_id_ex_imm,
    output t_word         o_id_ex_pc_plus4,
    output t_alu_ctl      o_id_ex_alu_ctl,
    output logic          o_id_ex_alu_src,      // Immediate as operand b
    output logic          o_id_ex_reg_write,
    output logic          o_id_ex_mem_read,
    output logic          o_id_ex_mem_write,
    output logic          o_id_ex_branch
);

    t_opcode  opcode;
    t_funct   funct;
    t_reg_idx rs, rt, rd;
    t_word    rs_data, rt_data, imm;
    t_alu_ctl alu_ctl;
    logic     alu_src, reg_write, mem_read, mem_write, branch, dst_rd;

    assign opcode     = i_if_id_instr[31:26];
    assign rs         = i_if_id_instr[25:21];
    assign rt         = i_if_id_instr[20:16];
    assign rd         = i_if_id_instr[15:11];
    assign funct      = i_if_id_instr[5:0];
    assign imm        = {{16{i_if_id_instr[15]}}, i_if_id_instr[15:0]}; // Sign extend
    assign o_if_id_rs = rs;
    assign o_if_id_rt = rt;

    register_file register_file_i (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_rs       (rs),
        .i_rt       (rt),
        .i_dbg_reg  (i_dbg_reg),
        .i_we       (i_wb_we),
        .i_wr_reg   (i_wb_reg),
        .i_wr_data  (i_wb_data),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data),
        .o_dbg_data (o_dbg_data)
    );

    always_comb begin
        alu_ctl   = ALU_ADD; // Unknown opcodes fall through as no-ops
        alu_src   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        dst_rd    = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                dst_rd    = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    FN_ADD:  alu_ctl = ALU_ADD;
                    FN_SUB:  alu_ctl = ALU_SUB;
                    FN_AND:  alu_ctl = ALU_AND;
                    FN_OR:   alu_ctl = ALU_OR;
                    FN_SLT:  alu_ctl = ALU_SLT;
                    default: reg_write = 1'b0; // Covers the all-zero word
                endcase
            end
            OP_ADDI: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            OP_LW: begin
                alu_src   = 1'b1; // Base plus offset
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            OP_BEQ: begin
                alu_ctl = ALU_SUB; // Zero flag gives equality
                branch  = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset || i_select_control_nop) begin
            o_id_ex_reg_write <= 1'b0;
            o_id_ex_mem_read  <= 1'b0;
            o_id_ex_mem_write <= 1'b0;
            o_id_ex_branch    <= 1'b0;
        end else begin
            o_id_ex_reg_write <= reg_write;
            o_id_ex_mem_read  <= mem_read;
            o_id_ex_mem_write <= mem_write;
            o_id_ex_branch    <= branch;
        end
    end

    always_ff @(posedge i_clock) begin
        o_id_ex_rs_data  <= rs_data;
        o_id_ex_rt_data  <= rt_data;
        o_id_ex_rs       <= rs;
        o_id_ex_rt       <= rt;
        o_id_ex_rd       <= dst_rd ? rd : rt;
        o_id_ex_imm      <= imm;
        o_id_ex_pc_plus4 <= i_if_id_pc_plus4;
        o_id_ex_alu_ctl  <= alu_ctl;
        o_id_ex_alu_src  <= alu_src;
    end

endmodule

`default_nettype wire

/* fetch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_stage import mips_pkg::*; #(
    parameter int IMEM_DEPTH = 64
) (
    input  wire                          i_clock,
    input  wire                          i_reset,
    input  wire                          i_imem_we,     // Program load, reset only
    input  wire [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,   // Word address
    input  wire t_word                   i_imem_data,
    input  wire                          i_enable_pc,    // Low during load-use stall
    input  wire                          i_enable_if_id,
    input  wire                          i_flush_if,     // Taken branch kills fetch
    input  wire                          i_branch_taken,
    input  wire t_word                   i_branch_target,
    output t_word                        o_pc,
    output t_word                        o_if_id_instr,
    output t_word                        o_if_id_pc_plus4
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    t_word imem [IMEM_DEPTH];
    t_word pc_plus4;
    t_word instr;

    assign pc_plus4 = o_pc + 32'd4;
    assign instr    = imem[o_pc[IMEM_AW+1:2]]; // Word aligned fetch

    always_ff @(posedge i_clock) begin
        if (i_reset && i_imem_we) imem[i_imem_addr] <= i_imem_data;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset)             o_pc <= '0;
        else if (i_branch_taken) o_pc <= i_branch_target; // Redirect from MEM
        else if (i_enable_pc)    o_pc <= pc_plus4;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset || i_flush_if) begin
            o_if_id_instr    <= '0; // All-zero word is a no-op
            o_if_id_pc_plus4 <= '0;
        end else if (i_enable_if_id) begin
            o_if_id_instr    <= instr;
            o_if_id_pc_plus4 <= pc_plus4;
        end
    end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/10ps
`default_nettype none

module register_file import mips_pkg::*; (
    input  wire           i_clock,
    input  wire           i_reset,
    input  wire t_reg_idx i_rs,       // Decode read ports
    input  wire t_reg_idx i_rt,
    input  wire t_reg_idx i_dbg_reg,  // Debug read index
    input  wire           i_we,       // Write-back port
    input  wire t_reg_idx i_wr_reg,
    input  wire t_word    i_wr_data,
    output t_word         o_rs_data,
    output t_word         o_rt_data,
    output t_word         o_dbg_data
);

    t_word regs [32];
    logic  wr_live; // Write that changes the array

    assign wr_live = i_we && (i_wr_reg != '0); // Register 0 stays zero

    // Write-through so decode sees a write of the same cycle
    assign o_rs_data  = (wr_live && (i_wr_reg == i_rs)) ? i_wr_data : regs[i_rs];
    assign o_rt_data  = (wr_live && (i_wr_reg == i_rt)) ? i_wr_data : regs[i_rt];
    assign o_dbg_data = regs[i_dbg_reg]; // Shows the value after the edge

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0; // Every program starts from zeros
            end
        end else if (wr_live) begin
            regs[i_wr_reg] <= i_wr_data;
        end
    end

endmodule

`default_nettype wire

/* forwarding_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module forwarding_unit import mips_pkg::*; (
    input  wire t_reg_idx i_id_ex_rs,         // Sources of the instruction in EX
    input  wire t_reg_idx i_id_ex_rt,
    input  wire t_reg_idx i_ex_mem_rd,        // Producer one stage ahead
    input  wire           i_ex_mem_reg_write,
    input  wire t_reg_idx i_mem_wb_rd,        // Producer two stages ahead
    input  wire           i_mem_wb_reg_write,
    output t_fwd_sel      o_fwd_a,            // Source of ALU operand a
    output t_fwd_sel      o_fwd_b             // Source of ALU operand b
);

    // Newest producer wins, register 0 never forwards
    function automatic t_fwd_sel pick_source(
        input t_reg_idx src,
        input t_reg_idx ex_mem_rd,
        input logic     ex_mem_we,
        input t_reg_idx mem_wb_rd,
        input logic     mem_wb_we
    );
        if (ex_mem_we && (ex_mem_rd != '0) && (ex_mem_rd == src))
            return FWD_EXMEM;
        if (mem_wb_we && (mem_wb_rd != '0) && (mem_wb_rd == src))
            return FWD_MEMWB;
        return FWD_REG;
    endfunction

    assign o_fwd_a = pick_source(i_id_ex_rs, i_ex_mem_rd, i_ex_mem_reg_write,
                                 i_mem_wb_rd, i_mem_wb_reg_write);
    assign o_fwd_b = pick_source(i_id_ex_rt, i_ex_mem_rd, i_ex_mem_reg_write,
                                 i_mem_wb_rd, i_mem_wb_reg_write);

endmodule

`default_nettype wire

/* stall_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module stall_unit import mips_pkg::*; (
    input  wire           i_reset,
    input  wire           i_branch_taken,       // Branch resolved taken in MEM
    input  wire           i_id_ex_mem_read,     // Load in EX
    input  wire t_reg_idx i_id_ex_rt,           // Load destination
    input  wire t_reg_idx i_if_id_rt,           // Sources of the instruction in ID
    input  wire t_reg_idx i_if_id_rs,
    output logic          o_select_control_nop, // Zero control into ID/EX
    output logic          o_enable_if_id,       // Low holds IF/ID
    output logic          o_enable_pc,          // Low holds the PC
    output logic          o_flush_if,           // No-op into IF/ID
    output logic          o_flush_ex            // Zero control into EX/MEM
);

    logic load_use; // ID needs the value still being loaded

    assign load_use = i_id_ex_mem_read &&
                      ((i_id_ex_rt == i_if_id_rs) || (i_id_ex_rt == i_if_id_rt));

    always_comb begin
        o_enable_pc          = 1'b1; // Normal flow unless overridden
        o_enable_if_id       = 1'b1;
        o_select_control_nop = 1'b0;
        o_flush_if           = 1'b0;
        o_flush_ex           = 1'b0;
        if (!i_reset) begin
            if (i_branch_taken) begin     // Control hazard wins over a stall
                o_flush_if           = 1'b1; // Kill the three younger instructions
                o_select_control_nop = 1'b1;
                o_flush_ex           = 1'b1;
            end else if (load_use) begin  // Data hazard on a load
                o_enable_pc          = 1'b0; // Hold fetch for one cycle
                o_enable_if_id       = 1'b0;
                o_select_control_nop = 1'b1; // Bubble into EX
            end
        end
    end

endmodule

`default_nettype wire

/* mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] t_word;    // Data and instruction word
    typedef logic [4:0]  t_reg_idx; // Register index
    typedef logic [5:0]  t_opcode;  // Opcode field, bits 31..26
    typedef logic [5:0]  t_funct;   // Function field, bits 5..0
    typedef logic [2:0]  t_alu_ctl; // ALU operation
    typedef logic [1:0]  t_fwd_sel; // ALU operand source

    localparam t_opcode OP_RTYPE = 6'h00; // add sub and or slt
    localparam t_opcode OP_ADDI  = 6'h08;
    localparam t_opcode OP_LW    = 6'h23;
    localparam t_opcode OP_SW    = 6'h2b;
    localparam t_opcode OP_BEQ   = 6'h04;

    localparam t_funct FN_ADD = 6'h20;
    localparam t_funct FN_SUB = 6'h22;
    localparam t_funct FN_AND = 6'h24;
    localparam t_funct FN_OR  = 6'h25;
    localparam t_funct FN_SLT = 6'h2a;

    localparam t_alu_ctl ALU_ADD = 3'd0;
    localparam t_alu_ctl ALU_SUB = 3'd1; // Also the beq compare
    localparam t_alu_ctl ALU_AND = 3'd2;
    localparam t_alu_ctl ALU_OR  = 3'd3;
    localparam t_alu_ctl ALU_SLT = 3'd4; // Signed less than

    localparam t_fwd_sel FWD_REG   = 2'd0; // Value read in decode
    localparam t_fwd_sel FWD_EXMEM = 2'd1; // ALU result one ahead
    localparam t_fwd_sel FWD_MEMWB = 2'd2; // Write-back value two ahead

endpackage

`default_nettype wire
